// ==== pe_pkg.sv ====
package pe_pkg;

  // array geometry
  // rows share a weight per column, columns share a pixel per row
  localparam int COLS = 4;
  localparam int ROWS = 4;

  // signed pixel width, enters at column 0
  localparam int X_BITS = 8;

  // signed weight width, one weight per column
  localparam int K_BITS = 8;

  // full precision product of one pixel and one weight
  localparam int M_BITS = X_BITS + K_BITS;

  // accumulator width, also the element width of an output word
  // sums wrap at this width
  localparam int Y_BITS = 24;

  // multiplier latency in enabled cycles
  // counts the input register in front of the multiplier
  // so the product pipe behind it is one stage shorter
  localparam int DELAY_MUL = 3;

endpackage

// ==== mac_ctrl_if.sv ====
interface mac_ctrl_if;

  // array wide enable, low while any finished result is stuck
  logic en;

  // per column clock enable of weight register and product pipe
  logic [pe_pkg::COLS-1:0] mul_en;

  // per column, product at the multiplier output is valid
  logic [pe_pkg::COLS-1:0] acc_en;

  // per column, load the product instead of adding to the old sum
  logic [pe_pkg::COLS-1:0] clear;

  // column control side
  modport controller (
    output en,
    output mul_en,
    output acc_en,
    output clear
  );

  // mac array side
  modport array (
    input en,
    input mul_en,
    input acc_en,
    input clear
  );

endinterface

// ==== acc_if.sv ====
interface acc_if;

  // per column, ROWS finished sums
  logic [pe_pkg::COLS-1:0][pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] acc_data;

  // per column, accumulator holds a finished group result
  logic [pe_pkg::COLS-1:0] acc_valid;

  // per column, that result closes the frame
  logic [pe_pkg::COLS-1:0] acc_last;

  // per column, shifter slot holds no unsent word
  logic [pe_pkg::COLS-1:0] slot_free;

  modport array (
    output acc_data
  );

  modport control (
    output acc_valid,
    output acc_last,
    input  slot_free
  );

  modport shifter (
    input  acc_data,
    input  acc_valid,
    input  acc_last,
    output slot_free
  );

endinterface

// ==== n_delay.sv ====
module n_delay #(
  parameter int N = 1,
  parameter int W = 1
) (
  input  logic         clk,
  input  logic         resetn,
  input  logic         en,
  input  logic [W-1:0] i,
  output logic [W-1:0] o
);

  // stage 0 takes the input, stage N-1 drives the output
  logic [N-1:0][W-1:0] stage;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      stage <= '0;
    end else if (en) begin
      // whole chain moves one step per enabled cycle
      stage[0] <= i;
      for (int k = 1; k < N; k++) begin
        stage[k] <= stage[k-1];
      end
    end
  end

  // held when en is low, so data lines up with other
  // pipes sharing the same enable
  assign o = stage[N-1];

endmodule

// ==== column_control.sv ====
module column_control (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic [pe_pkg::COLS-1:0] s_valid,
  input  logic [pe_pkg::COLS-1:0] s_last,
  input  logic [pe_pkg::COLS-1:0] s_cin_last,
  output logic                    s_ready,
  mac_ctrl_if.controller          ctrl,
  acc_if.control                  acc
);

  // flags after the multiplier latency, aligned with the products
  logic [pe_pkg::COLS-1:0][2:0] mul_flags;
  logic [pe_pkg::COLS-1:0]      mul_valid;
  logic [pe_pkg::COLS-1:0]      mul_cin_last;
  logic [pe_pkg::COLS-1:0]      mul_last;

  logic [pe_pkg::COLS-1:0] clear_q;
  logic [pe_pkg::COLS-1:0] acc_valid_q;
  logic [pe_pkg::COLS-1:0] acc_last_q;

  // load and freeze decisions
  logic [pe_pkg::COLS-1:0] can_load;
  logic [pe_pkg::COLS-1:0] freeze;
  logic                    en;
  logic [pe_pkg::COLS-1:0] acc_en;

  for (genvar c = 0; c < pe_pkg::COLS; c++) begin : g_col
    // valid, group end and frame end travel with the pixel
    // through input register and product pipe
    n_delay #(
      .N (pe_pkg::DELAY_MUL),
      .W (3)
    ) u_flag_pipe (
      .clk    (clk),
      .resetn (resetn),
      .en     (en),
      .i      ({s_valid[c], s_cin_last[c], s_last[c]}),
      .o      (mul_flags[c])
    );

    assign mul_valid[c]    = mul_flags[c][2];
    assign mul_cin_last[c] = mul_flags[c][1];
    assign mul_last[c]     = mul_flags[c][0];
  end

  // a slot takes a result only if the slot right of it is also free,
  // the last column has nothing to its right
  assign can_load = acc.slot_free & {1'b1, acc.slot_free[pe_pkg::COLS-1:1]};

  // a finished result that cannot leave would be overwritten
  // by the next product, so the whole array stops
  assign freeze = acc_valid_q & ~can_load;
  assign en     = ~|freeze;
  assign acc_en = mul_valid & {pe_pkg::COLS{en}};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      // first product after reset starts a fresh group
      clear_q     <= '1;
      acc_valid_q <= '0;
      acc_last_q  <= '0;
    end else begin
      for (int c = 0; c < pe_pkg::COLS; c++) begin
        // group end product arms the clear for the next product
        if (acc_en[c]) begin
          clear_q[c] <= mul_cin_last[c];
        end
        // set by the group end product, dropped by the shifter load
        if (acc_en[c] && mul_cin_last[c]) begin
          acc_valid_q[c] <= 1'b1;
          acc_last_q[c]  <= mul_last[c];
        end else if (can_load[c]) begin
          acc_valid_q[c] <= 1'b0;
        end
      end
    end
  end

  assign ctrl.en     = en;
  assign ctrl.mul_en = {pe_pkg::COLS{en}};
  assign ctrl.acc_en = acc_en;
  assign ctrl.clear  = clear_q;

  assign acc.acc_valid = acc_valid_q;
  assign acc.acc_last  = acc_last_q;

  // source may present a beat whenever the array moves
  assign s_ready = en;

endmodule

// ==== pe_array.sv ====
module pe_array (
  input  logic                                        clk,
  input  logic                                        resetn,
  input  logic [pe_pkg::ROWS-1:0][pe_pkg::X_BITS-1:0] s_data_pixels,
  input  logic [pe_pkg::COLS-1:0][pe_pkg::K_BITS-1:0] s_data_weights,
  mac_ctrl_if.array                                   ctrl,
  acc_if.array                                        acc
);

  // per row pixel shift register, index 0 is column 0
  logic [pe_pkg::ROWS-1:0][pe_pkg::COLS-1:0][pe_pkg::X_BITS-1:0] pix;

  // one weight register per column
  logic [pe_pkg::COLS-1:0][pe_pkg::K_BITS-1:0] wgt;

  // delayed products and their sign extended form
  logic [pe_pkg::COLS-1:0][pe_pkg::ROWS-1:0][pe_pkg::M_BITS-1:0] mul_q;
  logic [pe_pkg::COLS-1:0][pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] prod_ext;

  // running sums
  logic [pe_pkg::COLS-1:0][pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] acc_q;

  // pixels move right on every enabled cycle, valid or not
  always_ff @(posedge clk) begin
    if (ctrl.en) begin
      for (int r = 0; r < pe_pkg::ROWS; r++) begin
        pix[r] <= {pix[r][pe_pkg::COLS-2:0], s_data_pixels[r]};
      end
    end
  end

  // weight arrives already skewed by the source
  always_ff @(posedge clk) begin
    for (int c = 0; c < pe_pkg::COLS; c++) begin
      if (ctrl.mul_en[c]) begin
        wgt[c] <= s_data_weights[c];
      end
    end
  end

  for (genvar c = 0; c < pe_pkg::COLS; c++) begin : g_col
    for (genvar r = 0; r < pe_pkg::ROWS; r++) begin : g_row
      logic signed [pe_pkg::M_BITS-1:0] prod;

      assign prod = $signed(pix[r][c]) * $signed(wgt[c]);

      // rest of the multiplier latency after the input registers
      n_delay #(
        .N (pe_pkg::DELAY_MUL - 1),
        .W (pe_pkg::M_BITS)
      ) u_mul_pipe (
        .clk    (clk),
        .resetn (resetn),
        .en     (ctrl.mul_en[c]),
        .i      (prod),
        .o      (mul_q[c][r])
      );

      assign prod_ext[c][r] = {{(pe_pkg::Y_BITS - pe_pkg::M_BITS){mul_q[c][r][pe_pkg::M_BITS-1]}},
                               mul_q[c][r]};
    end
  end

  // clear drops the old sum so a new group starts from its first product
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc_q <= '0;
    end else begin
      for (int c = 0; c < pe_pkg::COLS; c++) begin
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          if (ctrl.acc_en[c]) begin
            acc_q[c][r] <= (ctrl.clear[c] ? '0 : acc_q[c][r]) + prod_ext[c][r];
          end
        end
      end
    end
  end

  assign acc.acc_data = acc_q;

endmodule

// ==== output_shifter.sv ====
module output_shifter (
  input  logic                                        clk,
  input  logic                                        resetn,
  input  logic                                        m_ready,
  output logic [pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] m_data,
  output logic                                        m_valid,
  output logic                                        m_last,
  acc_if.shifter                                      acc
);

  // one slot per column, the last slot faces the output
  logic [pe_pkg::COLS-1:0][pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] slot_data;
  logic [pe_pkg::COLS-1:0]                                       slot_valid;
  logic [pe_pkg::COLS-1:0]                                       slot_last;

  // slot takes part in draining the current group
  logic [pe_pkg::COLS-1:0] out_flag;

  // what each slot would take from its left neighbour
  logic [pe_pkg::COLS-1:0][pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] prev_data;
  logic [pe_pkg::COLS-1:0]                                       prev_valid;
  logic [pe_pkg::COLS-1:0]                                       prev_last;

  logic [pe_pkg::COLS-1:0] free_right;
  logic [pe_pkg::COLS-1:0] load;
  logic [pe_pkg::COLS-1:0] shift_en;
  logic [pe_pkg::COLS-1:0] last_in;

  // slot 0 pulls in an empty slot
  assign prev_data  = {slot_data[pe_pkg::COLS-2:0], {(pe_pkg::ROWS * pe_pkg::Y_BITS){1'b0}}};
  assign prev_valid = {slot_valid[pe_pkg::COLS-2:0], 1'b0};
  assign prev_last  = {slot_last[pe_pkg::COLS-2:0], 1'b0};

  // right neighbour free, always true past the last column
  assign free_right = {1'b1, ~slot_valid[pe_pkg::COLS-1:1]};

  // load is the handshake with the accumulator
  assign load = acc.acc_valid & ~slot_valid & free_right;

  // move while draining and the sink takes a word, or on a load
  assign shift_en = ({pe_pkg::COLS{m_ready}} & out_flag) | load;

  // column 0 is emitted last, so only it carries the frame end
  assign last_in = acc.acc_last & {{(pe_pkg::COLS-1){1'b0}}, 1'b1};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      slot_valid <= '0;
      slot_last  <= '0;
    end else begin
      for (int c = 0; c < pe_pkg::COLS; c++) begin
        if (shift_en[c]) begin
          slot_valid[c] <= load[c] | prev_valid[c];
          slot_last[c]  <= load[c] ? last_in[c] : prev_last[c];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < pe_pkg::COLS; c++) begin
      if (shift_en[c]) begin
        slot_data[c] <= load[c] ? acc.acc_data[c] : prev_data[c];
      end
    end
  end

  // results arrive column 0 first, so a load into the last slot
  // means the whole group is in place
  // each flag falls once its slot has emptied
  always_ff @(posedge clk) begin
    if (!resetn) begin
      out_flag <= '0;
    end else if (load[pe_pkg::COLS-1]) begin
      out_flag <= '1;
    end else begin
      out_flag <= out_flag & slot_valid;
    end
  end

  assign acc.slot_free = ~slot_valid;

  // last slot holds while the sink stalls
  assign m_data  = slot_data[pe_pkg::COLS-1];
  assign m_valid = slot_valid[pe_pkg::COLS-1] & out_flag[pe_pkg::COLS-1];
  assign m_last  = slot_last[pe_pkg::COLS-1];

endmodule

// ==== proc_engine.sv ====
module proc_engine (
  input  logic                                        clk,
  input  logic                                        resetn,

  // skewed input stream, column c runs c beats behind column 0
  input  logic [pe_pkg::COLS-1:0]                     s_valid,
  input  logic [pe_pkg::COLS-1:0]                     s_last,
  input  logic [pe_pkg::COLS-1:0]                     s_cin_last,
  input  logic [pe_pkg::ROWS-1:0][pe_pkg::X_BITS-1:0] s_data_pixels,
  input  logic [pe_pkg::COLS-1:0][pe_pkg::K_BITS-1:0] s_data_weights,
  output logic                                        s_ready,

  // one word of ROWS sums per transfer, last column first
  input  logic                                        m_ready,
  output logic [pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] m_data,
  output logic                                        m_valid,
  output logic                                        m_last
);

  mac_ctrl_if ctrl_bus ();
  acc_if      acc_bus ();

  // flag pipeline, clear, result valid and the array freeze
  column_control u_ctrl (
    .clk        (clk),
    .resetn     (resetn),
    .s_valid    (s_valid),
    .s_last     (s_last),
    .s_cin_last (s_cin_last),
    .s_ready    (s_ready),
    .ctrl       (ctrl_bus),
    .acc        (acc_bus)
  );

  // mac cells
  pe_array u_array (
    .clk            (clk),
    .resetn         (resetn),
    .s_data_pixels  (s_data_pixels),
    .s_data_weights (s_data_weights),
    .ctrl           (ctrl_bus),
    .acc            (acc_bus)
  );

  // result slots toward the output port
  output_shifter u_shift (
    .clk     (clk),
    .resetn  (resetn),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_valid (m_valid),
    .m_last  (m_last),
    .acc     (acc_bus)
  );

endmodule

// ==== proc_engine_tb.sv ====
module proc_engine_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // group table with one row per accumulation group
  // every group has at least COLS-1 beats
  // a shorter one would freeze the array on its column 0 result
  // before the previous group reaches the last column
  localparam int n_grp = 7;
  localparam int grp_len [n_grp] = '{5, 3, 7, 6, 9, 520, 4};
  // frame end on the final beat of the group
  localparam bit grp_last [n_grp] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
  // m_ready pattern while the group drains
  // each bit covers 4 cycles
  localparam logic [15:0] grp_duty [n_grp] = '{16'hffff, 16'hffff, 16'ha5a5, 16'h0001,
                                               16'h0101, 16'hffff, 16'h00ff};
  // -128 times -128 on every beat
  // 520 beats carry the sums past the signed range of Y_BITS
  localparam bit grp_ext [n_grp] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  localparam int max_cycles = 40000;

  logic                                        clk;
  logic                                        resetn;
  logic [pe_pkg::COLS-1:0]                     s_valid;
  logic [pe_pkg::COLS-1:0]                     s_last;
  logic [pe_pkg::COLS-1:0]                     s_cin_last;
  logic [pe_pkg::ROWS-1:0][pe_pkg::X_BITS-1:0] s_data_pixels;
  logic [pe_pkg::COLS-1:0][pe_pkg::K_BITS-1:0] s_data_weights;
  logic                                        s_ready;
  logic                                        m_ready;
  logic [pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] m_data;
  logic                                        m_valid;
  logic                                        m_last;

  // unskewed beat history
  logic [pe_pkg::ROWS-1:0][pe_pkg::X_BITS-1:0] beat_pix [$];
  logic [pe_pkg::COLS-1:0][pe_pkg::K_BITS-1:0] beat_wgt [$];
  logic                                        beat_cin [$];
  logic                                        beat_end [$];

  // expected words in arrival order
  logic [pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] exp_word [$];
  logic                                        exp_last [$];
  int                                          exp_grp [$];

  int word_errs;
  int flag_errs;
  int other_errs;

  proc_engine uut (
    .clk            (clk),
    .resetn         (resetn),
    .s_valid        (s_valid),
    .s_last         (s_last),
    .s_cin_last     (s_cin_last),
    .s_data_pixels  (s_data_pixels),
    .s_data_weights (s_data_weights),
    .s_ready        (s_ready),
    .m_ready        (m_ready),
    .m_data         (m_data),
    .m_valid        (m_valid),
    .m_last         (m_last)
  );

  always #4 clk = ~clk;

  task automatic verify_word(input string name,
                             input logic [pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] got,
                             input logic [pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      word_errs++;
    end
  endtask

  task automatic match_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      flag_errs++;
    end
  endtask

  // fills the beat history and the expected words from the group table
  task automatic build_groups();
    logic [pe_pkg::ROWS-1:0][pe_pkg::X_BITS-1:0]                   px;
    logic [pe_pkg::COLS-1:0][pe_pkg::K_BITS-1:0]                   wg;
    logic [pe_pkg::COLS-1:0][pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] sum;
    logic [31:0]                                                   rnd;
    int                                                            prod;
    for (int g = 0; g < n_grp; g++) begin
      sum = '0;
      for (int b = 0; b < grp_len[g]; b++) begin
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          rnd = $urandom();
          px[r] = grp_ext[g] ? 8'h80 : rnd[pe_pkg::X_BITS-1:0];
        end
        for (int c = 0; c < pe_pkg::COLS; c++) begin
          rnd = $urandom();
          wg[c] = grp_ext[g] ? 8'h80 : rnd[pe_pkg::K_BITS-1:0];
        end
        beat_pix.push_back(px);
        beat_wgt.push_back(wg);
        beat_cin.push_back(b == grp_len[g] - 1);
        beat_end.push_back(grp_last[g] && (b == grp_len[g] - 1));
        // signed products summed at Y_BITS so the sums wrap
        for (int c = 0; c < pe_pkg::COLS; c++) begin
          for (int r = 0; r < pe_pkg::ROWS; r++) begin
            prod = int'($signed(px[r])) * int'($signed(wg[c]));
            sum[c][r] = sum[c][r] + prod[pe_pkg::Y_BITS-1:0];
          end
        end
      end
      // last column leaves first and column 0 closes the group
      for (int c = pe_pkg::COLS - 1; c >= 0; c--) begin
        exp_word.push_back(sum[c]);
        exp_last.push_back(grp_last[g] && (c == 0));
        exp_grp.push_back(g);
      end
    end
  endtask

  // column c sees beat t-c while pixels enter unskewed at column 0
  task automatic drive_beat(input int t);
    int idx;
    for (int c = 0; c < pe_pkg::COLS; c++) begin
      idx = t - c;
      if (idx >= 0 && idx < beat_pix.size()) begin
        s_valid[c]        = 1'b1;
        s_cin_last[c]     = beat_cin[idx];
        s_last[c]         = beat_end[idx];
        s_data_weights[c] = beat_wgt[idx][c];
      end else begin
        s_valid[c]        = 1'b0;
        s_cin_last[c]     = 1'b0;
        s_last[c]         = 1'b0;
        s_data_weights[c] = '0;
      end
    end
    s_data_pixels = (t < beat_pix.size()) ? beat_pix[t] : '0;
  endtask

  initial begin
    int                                          t;
    int                                          got;
    int                                          cycles;
    int                                          extra;
    logic                                        prev_stall;
    logic                                        saw_stall;
    logic [pe_pkg::ROWS-1:0][pe_pkg::Y_BITS-1:0] prev_data;
    logic                                        prev_last;
    clk            = 1'b0;
    resetn         = 1'b0;
    s_valid        = '0;
    s_last         = '0;
    s_cin_last     = '0;
    s_data_pixels  = '0;
    s_data_weights = '0;
    m_ready        = 1'b0;
    word_errs      = 0;
    flag_errs      = 0;
    other_errs     = 0;
    void'($urandom(32'h6a75));
    build_groups();

    repeat (3) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    #1;
    // idle state straight out of reset
    match_flag("m_valid", m_valid, 1'b0);
    match_flag("s_ready", s_ready, 1'b1);

    t          = 0;
    got        = 0;
    cycles     = 0;
    extra      = 0;
    prev_stall = 1'b0;
    saw_stall  = 1'b0;
    prev_data  = '0;
    prev_last  = 1'b0;
    // drive at the falling edge and sample the settled outputs just after
    while (got < exp_word.size() && cycles < max_cycles) begin
      @(negedge clk);
      drive_beat(t);
      m_ready = grp_duty[exp_grp[got]][(cycles >> 2) % 16];
      #1;
      // a stalled word must not move
      if (prev_stall) begin
        match_flag("m_valid", m_valid, 1'b1);
        verify_word("m_data", m_data, prev_data);
        match_flag("m_last", m_last, prev_last);
      end
      if (!s_ready) begin
        saw_stall = 1'b1;
      end
      // beat is taken on the next rising edge
      if (s_ready) begin
        t++;
      end
      if (m_valid && m_ready) begin
        verify_word("m_data", m_data, exp_word[got]);
        match_flag("m_last", m_last, exp_last[got]);
        got++;
      end
      prev_stall = m_valid && !m_ready;
      prev_data  = m_data;
      prev_last  = m_last;
      cycles++;
    end

    if (got < exp_word.size()) begin
      $display("timeout: only %0d of %0d output words arrived", got, exp_word.size());
      other_errs++;
    end
    if (!saw_stall) begin
      $display("s_ready never dropped while the output was stalled");
      other_errs++;
    end

    // nothing more may come out once every word has been taken
    m_ready = 1'b1;
    repeat (20) begin
      @(negedge clk);
      drive_beat(t);
      t++;
      #1;
      if (m_valid) begin
        extra++;
      end
    end
    if (extra != 0) begin
      $display("an output word arrived after all expected words");
      other_errs++;
    end

    $display("errors: word %0d, flag %0d, other %0d", word_errs, flag_errs, other_errs);
    if (word_errs + flag_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
pe_pkg.sv
mac_ctrl_if.sv
acc_if.sv
n_delay.sv
column_control.sv
pe_array.sv
output_shifter.sv
proc_engine.sv
proc_engine_tb.sv

// ==== Makefile ====
TOP := proc_engine_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
